// ==== include/mem_if_defines.svh ====
/* widths, size codes and memory depth of the 32-bit to 16-bit memory subsystem
   size code 2'b11 is reserved and handled as a word */
`ifndef MEM_IF_DEFINES_SVH
`define MEM_IF_DEFINES_SVH

// line address and data widths
`define ADDR_W 12
`define LINE_W 16
`define WORD_W 32
`define BYTE_W 8

// number of lines in the memory array
`define MEM_DEPTH 4096

// access size codes
`define SIZE_BYTE 2'b00
`define SIZE_HALF 2'b01
`define SIZE_WORD 2'b10

// sign positions inside a line
`define SIGN_BIT_BYTE 7
`define SIGN_BIT_HALF 15

`endif

// ==== source/mem_if_pkg.sv ====
/* shared types of the memory subsystem; widths come from the defines header
   word data is split as bits 31:16 on line a and bits 15:0 on line a+1 */
`include "mem_if_defines.svh"

package mem_if_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`LINE_W-1:0] line_t;
  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [1:0]         acc_size_t;

  // request from the load/store unit
  typedef struct packed {
    logic      is_store;
    logic      is_signed;
    acc_size_t size;
    addr_t     addr;
    word_t     wdata;
  } mem_req_t;

  // decoded access, ready for the sequencer
  typedef struct packed {
    logic      is_store;
    logic      is_signed;
    acc_size_t size;
    logic      two_lines;
    logic      merge;
    addr_t     first_addr;
    addr_t     second_addr;
    line_t     first_line;
    line_t     second_line;
  } access_plan_t;

  typedef struct packed {
    logic  en;
    logic  we;
    addr_t addr;
    line_t wdata;
  } ram_cmd_t;

  typedef struct packed {
    word_t rdata;
  } mem_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    READ_FIRST,
    READ_SECOND,
    WRITE_FIRST,
    WRITE_SECOND,
    MERGE_WRITE,
    WAIT_RESULT
  } seq_state_t;

endpackage

// ==== source/access_decode.sv ====
/* one-entry holding register; a request taken here shows up as a plan next cycle
   the second line address wraps from the top line back to line zero */
`include "mem_if_defines.svh"

module access_decode (
  input  logic                     clk,
  input  logic                     rst_n,
  input  mem_if_pkg::mem_req_t     req,
  input  logic                     req_valid,
  input  logic                     plan_ready,
  output logic                     req_ready,
  output mem_if_pkg::access_plan_t plan,
  output logic                     plan_valid
);
  import mem_if_pkg::*;

  access_plan_t plan_d;
  logic         is_word;
  logic         take;

  // reserved code 2'b11 behaves as a word
  assign is_word   = req.size[1];
  assign req_ready = !plan_valid || plan_ready;
  assign take      = req_valid && req_ready;

  always_comb begin
    plan_d.is_store    = req.is_store;
    plan_d.is_signed   = req.is_signed;
    plan_d.size        = is_word ? acc_size_t'(`SIZE_WORD) : req.size;
    plan_d.two_lines   = is_word;
    plan_d.merge       = req.is_store && (req.size == `SIZE_BYTE);
    plan_d.first_addr  = req.addr;
    // natural wrap of the 12-bit sum
    plan_d.second_addr = req.addr + addr_t'(1);
    // upper half goes first for words, otherwise the low half is the whole line
    plan_d.first_line  = is_word ? req.wdata[`WORD_W-1:`LINE_W] : req.wdata[`LINE_W-1:0];
    plan_d.second_line = req.wdata[`LINE_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      plan_valid <= 1'b0;
    end else if (take) begin
      plan_valid <= 1'b1;
    end else if (plan_ready) begin
      plan_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      plan <= plan_d;
    end
  end

endmodule

// ==== source/access_sequencer.sv ====
/* issues the RAM commands of one plan at a time; starts only when the assembler can
   take the result, so no stall is needed inside an access */
`include "mem_if_defines.svh"

module access_sequencer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  mem_if_pkg::access_plan_t plan,
  input  logic                     plan_valid,
  input  mem_if_pkg::line_t        rd_line,
  input  logic                     asm_ready,
  output logic                     plan_ready,
  output mem_if_pkg::ram_cmd_t     ram_cmd,
  output logic                     line_valid,
  output logic                     line_last,
  output logic                     line_signed,
  output mem_if_pkg::acc_size_t    line_size
);
  import mem_if_pkg::*;

  seq_state_t               state;
  seq_state_t               state_d;
  access_plan_t             plan_q;
  logic                     rd_due;
  logic [`BYTE_W-1:0]       upper_q;

  assign plan_ready  = (state == IDLE) && asm_ready;
  assign line_signed = plan_q.is_signed;
  assign line_size   = plan_q.size;
  // read data returns one cycle after a read command
  assign line_valid  = rd_due;

  always_comb begin
    state_d = state;
    case (state)
      IDLE: begin
        if (plan_valid && plan_ready) begin
          state_d = plan.is_store && !plan.merge ? WRITE_FIRST : READ_FIRST;
        end
      end
      READ_FIRST: begin
        state_d = plan_q.two_lines ? READ_SECOND : WAIT_RESULT;
      end
      READ_SECOND: state_d = WAIT_RESULT;
      WRITE_FIRST: state_d = plan_q.two_lines ? WRITE_SECOND : IDLE;
      WRITE_SECOND: state_d = IDLE;
      MERGE_WRITE: state_d = IDLE;
      // byte store picks up the old upper byte here
      WAIT_RESULT: state_d = plan_q.merge ? MERGE_WRITE : IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    ram_cmd.en    = 1'b0;
    ram_cmd.we    = 1'b0;
    ram_cmd.addr  = plan_q.first_addr;
    ram_cmd.wdata = plan_q.first_line;
    case (state)
      READ_FIRST: ram_cmd.en = 1'b1;
      READ_SECOND: begin
        ram_cmd.en   = 1'b1;
        ram_cmd.addr = plan_q.second_addr;
      end
      WRITE_FIRST: begin
        ram_cmd.en = 1'b1;
        ram_cmd.we = 1'b1;
      end
      WRITE_SECOND: begin
        ram_cmd.en    = 1'b1;
        ram_cmd.we    = 1'b1;
        ram_cmd.addr  = plan_q.second_addr;
        ram_cmd.wdata = plan_q.second_line;
      end
      MERGE_WRITE: begin
        ram_cmd.en    = 1'b1;
        ram_cmd.we    = 1'b1;
        ram_cmd.wdata = {upper_q, plan_q.first_line[`BYTE_W-1:0]};
      end
      default: ram_cmd.en = 1'b0;
    endcase
  end

  // last step: final read return of a load, or the final write of a store
  always_comb begin
    case (state)
      WRITE_FIRST: line_last = !plan_q.two_lines;
      WRITE_SECOND: line_last = 1'b1;
      MERGE_WRITE: line_last = 1'b1;
      WAIT_RESULT: line_last = !plan_q.is_store;
      default: line_last = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= IDLE;
      rd_due <= 1'b0;
    end else begin
      state  <= state_d;
      rd_due <= ram_cmd.en && !ram_cmd.we;
    end
  end

  always_ff @(posedge clk) begin
    if (plan_valid && plan_ready) begin
      plan_q <= plan;
    end
    if (state == WAIT_RESULT && plan_q.merge) begin
      upper_q <= rd_line[`LINE_W-1:`BYTE_W];
    end
  end

endmodule

// ==== source/load_assembler.sv ====
/* builds the 32-bit response and holds it until the consumer takes it
   line_last without line_valid marks a finished store, answered with zero */
`include "mem_if_defines.svh"

module load_assembler (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mem_if_pkg::line_t     rd_line,
  input  logic                  line_valid,
  input  logic                  line_last,
  input  logic                  line_signed,
  input  mem_if_pkg::acc_size_t line_size,
  input  logic                  rsp_ready,
  output logic                  asm_ready,
  output mem_if_pkg::mem_rsp_t  rsp,
  output logic                  rsp_valid
);
  import mem_if_pkg::*;

  line_t first_q;
  word_t result;
  logic  sign_b;
  logic  sign_h;

  assign asm_ready = !rsp_valid || rsp_ready;
  assign sign_b    = line_signed && rd_line[`SIGN_BIT_BYTE];
  assign sign_h    = line_signed && rd_line[`SIGN_BIT_HALF];

  always_comb begin
    if (!line_valid) begin
      result = '0;
    end else begin
      case (line_size)
        `SIZE_BYTE: result = {{(`WORD_W-`BYTE_W){sign_b}}, rd_line[`BYTE_W-1:0]};
        `SIZE_HALF: result = {{(`WORD_W-`LINE_W){sign_h}}, rd_line};
        default: result = {first_q, rd_line};
      endcase
    end
  end

  // upper half of a word load arrives first
  always_ff @(posedge clk) begin
    if (line_valid && !line_last) begin
      first_q <= rd_line;
    end
    if (line_last) begin
      rsp.rdata <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (line_last) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

endmodule

// ==== source/halfword_ram.sv ====
/* 4096 x 16 single-port array, read data one cycle after the command
   rd_line keeps the last read value; writes leave it unchanged */
`include "mem_if_defines.svh"

module halfword_ram (
  input  logic                 clk,
  input  mem_if_pkg::ram_cmd_t ram_cmd,
  output mem_if_pkg::line_t    rd_line
);
  import mem_if_pkg::*;

  line_t mem [`MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (ram_cmd.en) begin
      if (ram_cmd.we) begin
        mem[ram_cmd.addr] <= ram_cmd.wdata;
      end else begin
        rd_line <= mem[ram_cmd.addr];
      end
    end
  end

endmodule

// ==== source/mem_subsystem_top.sv ====
/* load/store unit side of the memory; only request and response ports are visible
   responses come back in request order */
module mem_subsystem_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mem_if_pkg::mem_req_t req,
  input  logic                 req_valid,
  output logic                 req_ready,
  output mem_if_pkg::mem_rsp_t rsp,
  output logic                 rsp_valid,
  input  logic                 rsp_ready
);
  import mem_if_pkg::*;

  access_plan_t plan;
  logic         plan_valid;
  logic         plan_ready;
  ram_cmd_t     ram_cmd;
  line_t        rd_line;
  logic         line_valid;
  logic         line_last;
  logic         line_signed;
  acc_size_t    line_size;
  logic         asm_ready;

  access_decode i_access_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .req_valid  (req_valid),
    .plan_ready (plan_ready),
    .req_ready  (req_ready),
    .plan       (plan),
    .plan_valid (plan_valid)
  );

  access_sequencer i_access_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .plan        (plan),
    .plan_valid  (plan_valid),
    .rd_line     (rd_line),
    .asm_ready   (asm_ready),
    .plan_ready  (plan_ready),
    .ram_cmd     (ram_cmd),
    .line_valid  (line_valid),
    .line_last   (line_last),
    .line_signed (line_signed),
    .line_size   (line_size)
  );

  load_assembler i_load_assembler (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_line     (rd_line),
    .line_valid  (line_valid),
    .line_last   (line_last),
    .line_signed (line_signed),
    .line_size   (line_size),
    .rsp_ready   (rsp_ready),
    .asm_ready   (asm_ready),
    .rsp         (rsp),
    .rsp_valid   (rsp_valid)
  );

  halfword_ram i_halfword_ram (
    .clk     (clk),
    .ram_cmd (ram_cmd),
    .rd_line (rd_line)
  );

endmodule

// ==== verification/mem_subsystem_properties.sv ====
/* handshake properties bound into the subsystem top level
   stability checks are off while reset is low */
module mem_subsystem_properties (
  input logic                 clk,
  input logic                 rst_n,
  input mem_if_pkg::mem_req_t req,
  input logic                 req_valid,
  input logic                 req_ready,
  input mem_if_pkg::mem_rsp_t rsp,
  input logic                 rsp_valid,
  input logic                 rsp_ready
);
  import mem_if_pkg::*;

  // failed property count
  int failures = 0;

  // a waiting request keeps valid high and its fields unchanged
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      req_valid && !req_ready |=> req_valid && $stable(req))
    else begin
      failures++;
      $error("request dropped or changed before req_ready");
    end

  // held response under back-pressure
  rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
    else begin
      failures++;
      $error("response dropped or changed while rsp_ready was low");
    end

  rsp_idle_after_reset: assert property (@(posedge clk) !rst_n |=> !rsp_valid)
    else begin
      failures++;
      $error("rsp_valid high in the cycle after reset");
    end

endmodule

// ==== verification/mem_subsystem_tb.sv ====
/* table-driven testbench; requests and responses run as two parallel processes
   so that response back-pressure reaches the request side */
`include "mem_if_defines.svh"

module mem_subsystem_tb;
  import mem_if_pkg::*;

  localparam int         WAIT_LIMIT  = 200;
  localparam logic [7:0] RANDOM_HOLD = 8'hff;

  // one table row, the request plus its expected answer
  typedef struct packed {
    mem_req_t   req;
    word_t      exp_rdata;
    logic [7:0] holdoff;
  } test_entry_t;

  logic        clk;
  logic        rst_n;
  mem_req_t    req;
  logic        req_valid;
  logic        req_ready;
  mem_rsp_t    rsp;
  logic        rsp_valid;
  logic        rsp_ready;

  test_entry_t tests[$];
  integer      seed = 32'hae42d277;
  int          errors = 0;
  int          checks = 0;

  mem_subsystem_top i_mem_subsystem_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

  bind mem_subsystem_top mem_subsystem_properties i_mem_subsystem_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready)
  );

  always #5 clk = ~clk;

  task automatic add_test(input logic st, input logic sg, input acc_size_t size,
                          input addr_t addr, input word_t wdata, input word_t exp,
                          input logic [7:0] hold);
    test_entry_t t;
    t.req.is_store  = st;
    t.req.is_signed = sg;
    t.req.size      = size;
    t.req.addr      = addr;
    t.req.wdata     = wdata;
    t.exp_rdata     = exp;
    t.holdoff       = hold;
    tests.push_back(t);
  endtask

  task automatic build_tests();
    // word store, then word and halfword loads of both lines
    add_test(1'b1, 1'b0, `SIZE_WORD, 12'h010, 32'h7654c321, 32'h00000000, 8'd0);
    add_test(1'b0, 1'b0, `SIZE_WORD, 12'h010, 32'h0, 32'h7654c321, 8'd0);
    add_test(1'b0, 1'b0, `SIZE_HALF, 12'h010, 32'h0, 32'h00007654, 8'd0);
    add_test(1'b0, 1'b1, `SIZE_HALF, 12'h010, 32'h0, 32'h00007654, 8'd2);
    add_test(1'b0, 1'b0, `SIZE_HALF, 12'h011, 32'h0, 32'h0000c321, 8'd0);
    add_test(1'b0, 1'b1, `SIZE_HALF, 12'h011, 32'h0, 32'hffffc321, 8'd0);
    // byte store keeps the upper byte of the line
    add_test(1'b1, 1'b0, `SIZE_HALF, 12'h020, 32'h00001234, 32'h00000000, 8'd0);
    add_test(1'b1, 1'b0, `SIZE_BYTE, 12'h020, 32'h5555ab80, 32'h00000000, 8'd3);
    add_test(1'b0, 1'b0, `SIZE_HALF, 12'h020, 32'h0, 32'h00001280, 8'd0);
    add_test(1'b0, 1'b1, `SIZE_BYTE, 12'h020, 32'h0, 32'hffffff80, 8'd0);
    add_test(1'b0, 1'b0, `SIZE_BYTE, 12'h020, 32'h0, 32'h00000080, 8'd0);
    // word at the top line wraps to line zero
    add_test(1'b1, 1'b0, `SIZE_WORD, 12'hfff, 32'ha5a55a5a, 32'h00000000, 8'd0);
    add_test(1'b0, 1'b0, `SIZE_WORD, 12'hfff, 32'h0, 32'ha5a55a5a, 8'd0);
    add_test(1'b0, 1'b0, `SIZE_HALF, 12'h000, 32'h0, 32'h00005a5a, 8'd0);
    // back-to-back loads under random back-pressure
    add_test(1'b0, 1'b0, `SIZE_WORD, 12'h010, 32'h0, 32'h7654c321, RANDOM_HOLD);
    add_test(1'b0, 1'b0, `SIZE_HALF, 12'h020, 32'h0, 32'h00001280, RANDOM_HOLD);
    add_test(1'b0, 1'b1, `SIZE_BYTE, 12'h020, 32'h0, 32'hffffff80, RANDOM_HOLD);
    add_test(1'b0, 1'b1, `SIZE_HALF, 12'hfff, 32'h0, 32'hffffa5a5, RANDOM_HOLD);
    add_test(1'b0, 1'b0, `SIZE_WORD, 12'hfff, 32'h0, 32'ha5a55a5a, RANDOM_HOLD);
    add_test(1'b0, 1'b0, `SIZE_HALF, 12'h011, 32'h0, 32'h0000c321, RANDOM_HOLD);
    add_test(1'b0, 1'b1, `SIZE_HALF, 12'h000, 32'h0, 32'h00005a5a, 8'd6);
  endtask

  task automatic send_requests();
    int waited;
    foreach (tests[i]) begin
      req       = tests[i].req;
      req_valid = 1'b1;
      waited    = 0;
      // ready is stable from the falling edge up to the next rising edge
      @(negedge clk);
      while (!req_ready && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      assert (req_ready) else begin
        $display("request %0d was never accepted, req_ready stayed low", i);
        errors++;
      end
      @(posedge clk);
      #1;
    end
    req_valid = 1'b0;
  endtask

  task automatic collect_responses();
    int    waited;
    int    hold;
    word_t got;
    foreach (tests[i]) begin
      hold = tests[i].holdoff;
      if (tests[i].holdoff == RANDOM_HOLD) begin
        hold = $unsigned($random(seed)) % 8;
      end
      if (hold > 0) begin
        rsp_ready = 1'b0;
        repeat (hold) begin
          @(posedge clk);
          #1;
        end
      end
      rsp_ready = 1'b1;
      waited    = 0;
      @(negedge clk);
      while (!rsp_valid && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
      end
      assert (rsp_valid) else begin
        $display("no response arrived for entry %0d, rsp_valid stayed low", i);
        errors++;
      end
      if (rsp_valid) begin
        got = rsp.rdata;
        checks++;
        assert (got == tests[i].exp_rdata) else begin
          $display("error rsp.rdata entry %0d expected %h actual %h",
                   i, tests[i].exp_rdata, got);
          errors++;
        end
      end
      @(posedge clk);
      #1;
    end
  endtask

  initial begin
    logic extra_rsp;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    rsp_ready = 1'b0;
    extra_rsp = 1'b0;
    build_tests();
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    checks += 2;
    assert (req_ready === 1'b1) else begin
      $display("error req_ready expected %h actual %h", 1'b1, req_ready);
      errors++;
    end
    assert (rsp_valid === 1'b0) else begin
      $display("error rsp_valid expected %h actual %h", 1'b0, rsp_valid);
      errors++;
    end
    @(posedge clk);
    #1;
    fork
      send_requests();
      collect_responses();
    join
    // every request answered once, so the response side must stay quiet now
    repeat (10) begin
      @(negedge clk);
      if (rsp_valid) begin
        extra_rsp = 1'b1;
      end
    end
    checks++;
    assert (!extra_rsp) else begin
      $display("a response arrived after the last table entry was answered");
      errors++;
    end
    // handshake properties of the bound checker
    errors += i_mem_subsystem_top.i_mem_subsystem_properties.failures;
    $display("summary %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+include
source/mem_if_pkg.sv
source/access_decode.sv
source/access_sequencer.sv
source/load_assembler.sv
source/halfword_ram.sv
source/mem_subsystem_top.sv
verification/mem_subsystem_properties.sv
verification/mem_subsystem_tb.sv
